// File: include/baser_rx_config.svh
// widths are fixed by the 64b/66b block format; only the max frame length default may change
`ifndef BASER_RX_CONFIG_SVH
`define BASER_RX_CONFIG_SVH

// one 64b/66b block per clock
`define BASER_DATA_W 64
`define BASER_HDR_W 2
`define BASER_KEEP_W 8

// frame length counters saturate at all ones
`define BASER_LEN_W 16

// standard untagged maximum from destination through FCS
`define BASER_MAX_PKT_LEN_DEF 1518

`endif

// File: logic/baser_rx_pkg.sv
// types only; widths come from baser_rx_config.svh, which must be on the include path
`include "baser_rx_config.svh"

package baser_rx_pkg;

    typedef logic [`BASER_DATA_W-1:0] data_t;
    typedef logic [`BASER_HDR_W-1:0] hdr_t;
    typedef logic [`BASER_KEEP_W-1:0] keep_t;
    typedef logic [`BASER_LEN_W-1:0] len_t;

    typedef enum logic [1:0] {
        sync_data = 2'b10,
        sync_ctrl = 2'b01
    } sync_e;

    // control block type field in lane 0 of a control block
    typedef enum logic [7:0] {
        blk_ctrl     = 8'h1e,
        blk_os_4     = 8'h2d,
        blk_start_4  = 8'h33,
        blk_os_start = 8'h66,
        blk_os_04    = 8'h55,
        blk_start_0  = 8'h78,
        blk_os_0     = 8'h4b,
        blk_term_0   = 8'h87,
        blk_term_1   = 8'h99,
        blk_term_2   = 8'haa,
        blk_term_3   = 8'hb4,
        blk_term_4   = 8'hcc,
        blk_term_5   = 8'hd2,
        blk_term_6   = 8'he1,
        blk_term_7   = 8'hff
    } block_type_e;

    // bit 3 marks a terminate, bits 2:0 then hold its data byte count
    typedef enum logic [3:0] {
        lane_idle   = 4'd0,
        lane_error  = 4'd1,
        lane_data   = 4'd4,
        lane_term_0 = 4'd8,
        lane_term_1 = 4'd9,
        lane_term_2 = 4'd10,
        lane_term_3 = 4'd11,
        lane_term_4 = 4'd12,
        lane_term_5 = 4'd13,
        lane_term_6 = 4'd14,
        lane_term_7 = 4'd15
    } lane_type_e;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_last
    } rx_state_e;

endpackage

// File: logic/baser_block_if.sv
// decoded block pipeline; every signal is driven by the decoder, one block per clock, no stall
`timescale 1ns/1ps

interface baser_block_if;

    // d0 is one cycle behind the serdes input, d1 two
    baser_rx_pkg::data_t data_d0;
    baser_rx_pkg::data_t data_d1;
    baser_rx_pkg::lane_type_e type_d0;
    baser_rx_pkg::lane_type_e type_d1;
    logic start_d1;

    modport decoder (
        output data_d0, data_d1, type_d0, type_d1, start_d1
    );

    modport fsm (
        input type_d0, data_d1, type_d1, start_d1
    );

    modport crc (
        input data_d0
    );

endinterface

// File: logic/baser_block_decoder.sv
// start_4 and os_start are treated as plain control blocks; frames must start in lane 0
`timescale 1ns/1ps
`include "baser_rx_config.svh"

module baser_block_decoder (
    input  logic                clk,
    input  logic                reset_crc,
    input  baser_rx_pkg::data_t rx_data,
    input  baser_rx_pkg::hdr_t  rx_hdr,
    baser_block_if.decoder      blk,
    output logic                err_bad_block,
    output logic                err_framing
);

    baser_rx_pkg::data_t data_masked;
    baser_rx_pkg::lane_type_e lane_next;
    logic is_start;
    logic bad_block;
    logic framing;
    logic frame_open;
    logic frame_next;
    logic start_d0;

    // classify block, track frame boundaries
    always_comb begin
        lane_next = baser_rx_pkg::lane_error;
        is_start = 1'b0;
        bad_block = 1'b0;
        framing = 1'b0;
        frame_next = frame_open;
        if (rx_hdr == baser_rx_pkg::sync_data) begin
            lane_next = baser_rx_pkg::lane_data;
            framing = !frame_open;
        end else if (rx_hdr == baser_rx_pkg::sync_ctrl) begin
            frame_next = 1'b0;
            case (rx_data[7:0])
                baser_rx_pkg::blk_ctrl, baser_rx_pkg::blk_os_4, baser_rx_pkg::blk_os_04,
                baser_rx_pkg::blk_os_0, baser_rx_pkg::blk_start_4,
                baser_rx_pkg::blk_os_start: begin
                    lane_next = baser_rx_pkg::lane_idle;
                    framing = frame_open;
                end
                baser_rx_pkg::blk_start_0: begin
                    lane_next = baser_rx_pkg::lane_idle;
                    is_start = 1'b1;
                    frame_next = 1'b1;
                    framing = frame_open;
                end
                baser_rx_pkg::blk_term_0, baser_rx_pkg::blk_term_1, baser_rx_pkg::blk_term_2,
                baser_rx_pkg::blk_term_3, baser_rx_pkg::blk_term_4, baser_rx_pkg::blk_term_5,
                baser_rx_pkg::blk_term_6, baser_rx_pkg::blk_term_7: begin
                    // type bits 6:4 give the data byte count
                    lane_next = baser_rx_pkg::lane_type_e'({1'b1, rx_data[6:4]});
                    framing = !frame_open;
                end
                default: begin
                    bad_block = 1'b1;
                end
            endcase
        end else begin
            bad_block = 1'b1;
            frame_next = 1'b0;
        end
    end

    // drop the type byte of a terminate and zero everything past the last data byte
    always_comb begin
        data_masked = rx_data;
        if (lane_next[3]) begin
            data_masked = '0;
            for (int i = 0; i < `BASER_KEEP_W - 1; i++) begin
                if (i < int'(lane_next[2:0])) begin
                    data_masked[i*8 +: 8] = rx_data[(i+1)*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        blk.data_d0 <= data_masked;
        blk.data_d1 <= blk.data_d0;
        blk.type_d0 <= lane_next;
        blk.type_d1 <= blk.type_d0;
        start_d0 <= is_start;
        blk.start_d1 <= start_d0;
        frame_open <= frame_next;
        err_bad_block <= bad_block;
        err_framing <= framing;
        if (reset_crc) begin
            blk.type_d0 <= baser_rx_pkg::lane_idle;
            blk.type_d1 <= baser_rx_pkg::lane_idle;
            start_d0 <= 1'b0;
            blk.start_d1 <= 1'b0;
            frame_open <= 1'b0;
            err_bad_block <= 1'b0;
            err_framing <= 1'b0;
        end
    end

endmodule

// File: logic/baser_crc_checker.sv
// Ethernet CRC-32, reflected, bytes taken lane 0 first; trailing bytes must be zero-masked
`timescale 1ns/1ps
`include "baser_rx_config.svh"

module baser_crc_checker (
    input  logic                clk,
    input  logic                reset_crc,
    baser_block_if.crc          blk,
    input  logic                crc_restart,
    output baser_rx_pkg::keep_t crc_match,
    output baser_rx_pkg::keep_t crc_match_saved
);

    // expected state when the FCS ends after byte i with zero bytes folded behind it
    localparam logic [31:0] residue [8] = '{
        ~32'h6b87b1ec, ~32'he38a6876, ~32'he60914ae, ~32'h6522df69,
        ~32'h9d6cdf7e, ~32'hb1c2a1a3, ~32'hc622f71d, ~32'h2144df1c
    };

    logic [31:0] crc_state;
    logic [31:0] crc_next;

    function automatic logic [31:0] crc_fold(
        input logic [31:0]         crc,
        input baser_rx_pkg::data_t data
    );
        logic [31:0] c;
        int b;
        int k;
        c = crc;
        for (b = 0; b < `BASER_KEEP_W; b++) begin
            c = c ^ {24'd0, data[b*8 +: 8]};
            for (k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return c;
    endfunction

    assign crc_next = crc_fold(crc_state, blk.data_d0);

    always_comb begin
        for (int i = 0; i < `BASER_KEEP_W; i++) begin
            crc_match[i] = crc_next == residue[i];
        end
    end

    always_ff @(posedge clk) begin
        crc_state <= crc_restart ? '1 : crc_next;
        crc_match_saved <= crc_match;
        if (reset_crc) begin
            crc_state <= '1;
            crc_match_saved <= '0;
        end
    end

endmodule

// File: logic/baser_frame_fsm.sv
// no back-pressure, the consumer takes every beat; cfg_rx_enable is sampled only at frame start
`timescale 1ns/1ps
`include "baser_rx_config.svh"

module baser_frame_fsm (
    input  logic                clk,
    input  logic                reset_crc,
    baser_block_if.fsm          blk,
    input  baser_rx_pkg::keep_t crc_match,
    input  baser_rx_pkg::keep_t crc_match_saved,
    output logic                crc_restart,
    input  baser_rx_pkg::len_t  cfg_rx_max_pkt_len,
    input  logic                cfg_rx_enable,
    output baser_rx_pkg::data_t m_tdata,
    output baser_rx_pkg::keep_t m_tkeep,
    output logic                m_tvalid,
    output logic                m_tlast,
    output logic                m_tuser,
    output baser_rx_pkg::len_t  stat_pkt_len,
    output logic                stat_pkt_good,
    output logic                stat_pkt_bad,
    output logic                stat_err_bad_fcs,
    output logic                stat_err_oversize,
    output logic                stat_pkt_fragment,
    output logic                stat_pkt_jabber,
    output logic                stat_err_preamble
);

    // preamble and SFD in lanes 1 to 7 of the start block
    localparam logic [55:0] pre_sfd = 56'hd5_5555_5555_5555;

    baser_rx_pkg::rx_state_e state, state_next;
    baser_rx_pkg::len_t frame_len, frame_len_next;
    baser_rx_pkg::len_t len_lim, len_lim_next;
    baser_rx_pkg::len_t len_close;
    baser_rx_pkg::keep_t keep_next;
    logic oversize, oversize_next;
    logic pre_ok, pre_ok_next;
    logic beat;
    logic close;
    logic ctrl_end;
    logic fcs_ok;
    logic good;

    always_comb begin
        state_next = baser_rx_pkg::st_idle;
        crc_restart = 1'b0;
        len_lim_next = '0;
        oversize_next = oversize;
        pre_ok_next = pre_ok;
        keep_next = '0;
        beat = 1'b0;
        close = 1'b0;
        ctrl_end = 1'b0;
        fcs_ok = 1'b0;
        len_close = frame_len;

        // saturating byte count that already includes the d1 block
        frame_len_next = '1;
        if (&frame_len[`BASER_LEN_W-1:3] == 1'b0) begin
            if (blk.type_d0[3]) begin
                frame_len_next = frame_len + baser_rx_pkg::len_t'(blk.type_d0[2:0]);
            end else begin
                frame_len_next = frame_len + baser_rx_pkg::len_t'(`BASER_KEEP_W);
            end
        end
        if (len_lim[`BASER_LEN_W-1:3] != '0) begin
            len_lim_next = len_lim - baser_rx_pkg::len_t'(`BASER_KEEP_W);
        end

        case (state)
            baser_rx_pkg::st_idle: begin
                crc_restart = 1'b1;
                frame_len_next = baser_rx_pkg::len_t'(`BASER_KEEP_W);
                len_lim_next = cfg_rx_max_pkt_len;
                pre_ok_next = blk.data_d1[63:8] == pre_sfd;
                if (blk.start_d1 && cfg_rx_enable) begin
                    crc_restart = 1'b0;
                    state_next = baser_rx_pkg::st_payload;
                end
            end
            baser_rx_pkg::st_payload: begin
                beat = 1'b1;
                keep_next = '1;
                if (blk.type_d0[3]) begin
                    oversize_next = len_lim < baser_rx_pkg::len_t'(8 + blk.type_d0[2:0]);
                end else begin
                    oversize_next = len_lim < baser_rx_pkg::len_t'(8);
                end
                if (blk.type_d0 == baser_rx_pkg::lane_data) begin
                    state_next = baser_rx_pkg::st_payload;
                end else if (blk.type_d0[3]) begin
                    crc_restart = 1'b1;
                    if (blk.type_d0[2:0] <= 3'd4) begin
                        // FCS ends in d1 or in the low lanes of d0
                        keep_next = 8'hff >> (3'd4 - blk.type_d0[2:0]);
                        close = 1'b1;
                        len_close = frame_len_next;
                        if (blk.type_d0[2:0] == 3'd0) begin
                            fcs_ok = crc_match_saved[7];
                        end else begin
                            fcs_ok = crc_match[blk.type_d0[2:0] - 3'd1];
                        end
                    end else begin
                        state_next = baser_rx_pkg::st_last;
                    end
                end else begin
                    // idle or error inside the frame
                    crc_restart = 1'b1;
                    close = 1'b1;
                    ctrl_end = 1'b1;
                    len_close = frame_len_next;
                end
            end
            baser_rx_pkg::st_last: begin
                // up to three bytes spill over from the terminate block
                beat = 1'b1;
                crc_restart = 1'b1;
                close = 1'b1;
                keep_next = 8'hff >> (4'd12 - {1'b0, blk.type_d1[2:0]});
                fcs_ok = crc_match_saved[blk.type_d1[2:0] - 3'd1];
            end
            default: begin
                state_next = baser_rx_pkg::st_idle;
            end
        endcase
    end

    assign good = close && fcs_ok && !oversize_next;

    always_ff @(posedge clk) begin
        state <= state_next;
        frame_len <= frame_len_next;
        len_lim <= len_lim_next;
        oversize <= oversize_next;
        pre_ok <= pre_ok_next;
        m_tdata <= blk.data_d1;
        m_tkeep <= keep_next;
        m_tvalid <= beat;
        m_tlast <= close;
        m_tuser <= close && !good;
        stat_pkt_len <= close ? len_close : '0;
        stat_pkt_good <= good;
        stat_pkt_bad <= close && !good;
        stat_err_bad_fcs <= close && !fcs_ok && !ctrl_end;
        stat_err_oversize <= close && oversize_next;
        stat_pkt_fragment <= close && !fcs_ok && (len_close[`BASER_LEN_W-1:6] == '0);
        stat_pkt_jabber <= close && !fcs_ok && oversize_next;
        stat_err_preamble <= close && !pre_ok;
        if (reset_crc) begin
            state <= baser_rx_pkg::st_idle;
            oversize <= 1'b0;
            pre_ok <= 1'b0;
            m_tvalid <= 1'b0;
            m_tlast <= 1'b0;
            m_tuser <= 1'b0;
            stat_pkt_len <= '0;
            stat_pkt_good <= 1'b0;
            stat_pkt_bad <= 1'b0;
            stat_err_bad_fcs <= 1'b0;
            stat_err_oversize <= 1'b0;
            stat_pkt_fragment <= 1'b0;
            stat_pkt_jabber <= 1'b0;
            stat_err_preamble <= 1'b0;
        end
    end

endmodule

// File: logic/baser_rx_top.sv
// 10GBASE-R receiver, one 66-bit block per clock, FCS stripped, no PTP, lane 0 starts only
`timescale 1ns/1ps

module baser_rx_top (
    input  logic                clk,
    input  logic                reset_crc,
    input  baser_rx_pkg::data_t rx_data,
    input  baser_rx_pkg::hdr_t  rx_hdr,
    input  baser_rx_pkg::len_t  cfg_rx_max_pkt_len,
    input  logic                cfg_rx_enable,
    output baser_rx_pkg::data_t m_tdata,
    output baser_rx_pkg::keep_t m_tkeep,
    output logic                m_tvalid,
    output logic                m_tlast,
    output logic                m_tuser,
    output baser_rx_pkg::len_t  stat_pkt_len,
    output logic                stat_pkt_good,
    output logic                stat_pkt_bad,
    output logic                stat_err_bad_fcs,
    output logic                stat_err_oversize,
    output logic                stat_pkt_fragment,
    output logic                stat_pkt_jabber,
    output logic                stat_err_preamble,
    output logic                stat_err_bad_block,
    output logic                stat_err_framing
);

    baser_rx_pkg::keep_t crc_match;
    baser_rx_pkg::keep_t crc_match_saved;
    logic crc_restart;

    baser_block_if blk ();

    baser_block_decoder i_decoder (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .rx_data       (rx_data),
        .rx_hdr        (rx_hdr),
        .blk           (blk.decoder),
        .err_bad_block (stat_err_bad_block),
        .err_framing   (stat_err_framing)
    );

    baser_crc_checker i_crc (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .blk             (blk.crc),
        .crc_restart     (crc_restart),
        .crc_match       (crc_match),
        .crc_match_saved (crc_match_saved)
    );

    baser_frame_fsm i_fsm (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .blk                (blk.fsm),
        .crc_match          (crc_match),
        .crc_match_saved    (crc_match_saved),
        .crc_restart        (crc_restart),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .cfg_rx_enable      (cfg_rx_enable),
        .m_tdata            (m_tdata),
        .m_tkeep            (m_tkeep),
        .m_tvalid           (m_tvalid),
        .m_tlast            (m_tlast),
        .m_tuser            (m_tuser),
        .stat_pkt_len       (stat_pkt_len),
        .stat_pkt_good      (stat_pkt_good),
        .stat_pkt_bad       (stat_pkt_bad),
        .stat_err_bad_fcs   (stat_err_bad_fcs),
        .stat_err_oversize  (stat_err_oversize),
        .stat_pkt_fragment  (stat_pkt_fragment),
        .stat_pkt_jabber    (stat_pkt_jabber),
        .stat_err_preamble  (stat_err_preamble)
    );

endmodule

// File: sim/baser_rx_assertions.sv
// checks only the per-frame status pulses because the decoder error flags are not tied to tlast
`timescale 1ns/1ps

module baser_rx_assertions (
    input logic clk,
    input logic reset_crc,
    input logic m_tvalid,
    input logic m_tlast,
    input logic stat_pkt_good,
    input logic stat_pkt_bad,
    input logic stat_err_bad_fcs,
    input logic stat_err_oversize,
    input logic stat_pkt_fragment,
    input logic stat_pkt_jabber,
    input logic stat_err_preamble
);

    int fail_count = 0;
    logic any_status;

    assign any_status = stat_pkt_good | stat_pkt_bad | stat_err_bad_fcs | stat_err_oversize
        | stat_pkt_fragment | stat_pkt_jabber | stat_err_preamble;

    tlast_needs_tvalid: assert property (
        @(posedge clk) disable iff (reset_crc) m_tlast |-> m_tvalid
    ) else begin
        $error("tlast raised without tvalid");
        fail_count++;
    end

    good_and_bad_exclusive: assert property (
        @(posedge clk) disable iff (reset_crc) !(stat_pkt_good && stat_pkt_bad)
    ) else begin
        $error("frame reported good and bad at once");
        fail_count++;
    end

    // status belongs to the closing beat
    status_on_tlast: assert property (
        @(posedge clk) disable iff (reset_crc) any_status |-> m_tlast
    ) else begin
        $error("status pulse outside a tlast beat");
        fail_count++;
    end

endmodule

bind baser_rx_top baser_rx_assertions i_assertions (.*);

// File: sim/baser_rx_tb.sv
// frames start in lane 0 and carry 64 to 191 bytes with FCS; blocks arrive every clock
`timescale 1ns/1ps
`include "baser_rx_config.svh"

module baser_rx_tb;

    // terminate block type codes of the 64b/66b format by data byte count
    localparam logic [7:0] term_codes [8] = '{
        8'h87, 8'h99, 8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff
    };
    localparam logic [63:0] idle_blk = 64'h1e;

    logic clk = 1'b0;
    logic reset_crc;
    baser_rx_pkg::data_t rx_data;
    baser_rx_pkg::hdr_t rx_hdr;
    baser_rx_pkg::len_t cfg_rx_max_pkt_len;
    logic cfg_rx_enable;
    baser_rx_pkg::data_t m_tdata;
    baser_rx_pkg::keep_t m_tkeep;
    baser_rx_pkg::len_t stat_pkt_len;
    wire m_tvalid, m_tlast, m_tuser;
    wire stat_pkt_good, stat_pkt_bad, stat_err_bad_fcs, stat_err_oversize;
    wire stat_pkt_fragment, stat_pkt_jabber, stat_err_preamble;
    wire stat_err_bad_block, stat_err_framing;
    wire [6:0] stat_vec;

    integer seed = 32'h5c35;
    logic [7:0] frame_q[$];
    logic [7:0] out_bytes[$];
    string failed_names[$];
    int tests = 0;
    int beats = 0;
    int pulses = 0;
    int lasts = 0;
    int bad_block_seen = 0;
    int framing_seen = 0;
    baser_rx_pkg::keep_t last_keep;
    logic last_user;
    baser_rx_pkg::len_t last_len;
    logic [6:0] last_stat;

    baser_rx_top i_dut (.*);

    always #50 clk = ~clk;

    // good, bad, bad fcs, oversize, fragment, jabber, preamble
    assign stat_vec = {stat_pkt_good, stat_pkt_bad, stat_err_bad_fcs, stat_err_oversize,
                       stat_pkt_fragment, stat_pkt_jabber, stat_err_preamble};

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset_crc) begin
            beats += m_tvalid;
            pulses += (stat_vec != 0);
            bad_block_seen += stat_err_bad_block;
            framing_seen += stat_err_framing;
            if (m_tvalid) begin
                for (int i = 0; i < 8; i++) begin
                    if (m_tkeep[i]) begin
                        out_bytes.push_back(m_tdata[i*8 +: 8]);
                    end
                end
            end
            if (m_tlast) begin
                lasts++;
                last_keep = m_tkeep;
                last_user = m_tuser;
                last_len = stat_pkt_len;
                last_stat = stat_vec;
            end
        end
    end

    task automatic put_block(input baser_rx_pkg::hdr_t hdr, input baser_rx_pkg::data_t data);
        @(posedge clk);
        #1;
        rx_hdr = hdr;
        rx_data = data;
    endtask

    // random payload, then the FCS least significant byte first
    task automatic make_frame(input int len, input bit corrupt);
        logic [31:0] c;
        c = 32'hffffffff;
        frame_q.delete();
        for (int i = 0; i < len - 4; i++) begin
            frame_q.push_back(8'($random(seed)));
            c = c ^ {24'd0, frame_q[i]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(~c[i*8 +: 8]);
        end
        if (corrupt) begin
            frame_q[len - 2] ^= 8'h5a;
        end
    endtask

    // start block, data blocks, terminate, idle gap
    task automatic transmit(input logic [7:0] sfd, input bit abort);
        baser_rx_pkg::data_t d;
        int nblk;
        nblk = abort ? 3 : frame_q.size() / 8;
        put_block(2'b01, {sfd, 48'h5555_5555_5555, 8'h78});
        for (int b = 0; b < nblk; b++) begin
            for (int i = 0; i < 8; i++) begin
                d[i*8 +: 8] = frame_q[b*8 + i];
            end
            put_block(2'b10, d);
        end
        if (!abort) begin
            d = '0;
            d[7:0] = term_codes[frame_q.size() % 8];
            for (int i = 0; i < frame_q.size() % 8; i++) begin
                d[(i+1)*8 +: 8] = frame_q[nblk*8 + i];
            end
            put_block(2'b01, d);
        end
        repeat (3) put_block(2'b01, idle_blk);
    endtask

    task automatic report_test(input string name, input int errs);
        tests++;
        if (errs == 0) begin
            $display("%s passed", name);
        end else begin
            $display("%s failed with %0d errors", name, errs);
            failed_names.push_back(name);
        end
    endtask

    task automatic run_frame(input string name, input int len, input bit corrupt,
                             input logic [7:0] sfd, input bit abort, input logic [6:0] exp_stat);
        logic [7:0] exp_keep;
        int errs;
        int wrong;
        exp_keep = 8'hff >> ((8 - (len - 4) % 8) % 8);
        errs = 0;
        wrong = 0;
        make_frame(len, corrupt);
        out_bytes.delete();
        lasts = 0;
        transmit(sfd, abort);
        for (int t = 0; t < 20 && lasts == 0; t++) begin
            put_block(2'b01, idle_blk);
        end
        assert (lasts == 1) else begin
            $display("%s saw %0d frame ends instead of one before the timeout", name, lasts);
            errs++;
        end
        assert (last_user == !exp_stat[6] && last_stat == exp_stat) else begin
            $display("mismatch at %0t: %s tuser %b status %b, expected tuser %b status %b",
                     $time, name, last_user, last_stat, !exp_stat[6], exp_stat);
            errs++;
        end
        if (!abort) begin
            for (int i = 0; i < out_bytes.size() && i < len - 4; i++) begin
                wrong += (out_bytes[i] !== frame_q[i]);
            end
            assert (out_bytes.size() == len - 4 && wrong == 0) else begin
                $display("mismatch at %0t: %s got %0d bytes with %0d wrong, expected %0d",
                         $time, name, out_bytes.size(), wrong, len - 4);
                errs++;
            end
            assert (last_keep == exp_keep && last_len == len) else begin
                $display("mismatch at %0t: %s tkeep %h length %0d, expected %h and %0d",
                         $time, name, last_keep, last_len, exp_keep, len);
                errs++;
            end
        end
        report_test(name, errs);
    endtask

    // sync header 2'b10 between frames is a framing error, anything else here a bad block
    task automatic run_block_error(input string name, input baser_rx_pkg::hdr_t hdr);
        int errs;
        errs = 0;
        bad_block_seen = 0;
        framing_seen = 0;
        put_block(hdr, {$random(seed), $random(seed)});
        for (int t = 0; t < 10 && bad_block_seen + framing_seen == 0; t++) begin
            put_block(2'b01, idle_blk);
        end
        assert (hdr == 2'b10 ? (framing_seen == 1 && bad_block_seen == 0)
                             : (bad_block_seen == 1 && framing_seen == 0)) else begin
            $display("%s raised %0d bad block and %0d framing flags before the timeout",
                     name, bad_block_seen, framing_seen);
            errs++;
        end
        report_test(name, errs);
    endtask

    initial begin
        int len;
        int errs;
        reset_crc = 1'b1;
        rx_hdr = 2'b01;
        rx_data = idle_blk;
        cfg_rx_max_pkt_len = `BASER_MAX_PKT_LEN_DEF;
        cfg_rx_enable = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        repeat (4) put_block(2'b01, idle_blk);

        // one frame per terminate position
        for (int r = 0; r < 8; r++) begin
            len = 64 + 8 * ($unsigned($random(seed)) % 16) + r;
            run_frame($sformatf("good_term_%0d", r), len, 1'b0, 8'hd5, 1'b0, 7'b1000000);
        end
        run_frame("bad_fcs", 104, 1'b1, 8'hd5, 1'b0, 7'b0110000);
        cfg_rx_max_pkt_len = 16'd64;
        run_frame("oversize", 123, 1'b0, 8'hd5, 1'b0, 7'b0101000);
        run_frame("oversize_jabber", 141, 1'b1, 8'hd5, 1'b0, 7'b0111010);
        cfg_rx_max_pkt_len = `BASER_MAX_PKT_LEN_DEF;
        run_frame("bad_sfd", 77, 1'b0, 8'hd4, 1'b0, 7'b1000001);
        // cut after three data blocks, so the frame is also a fragment
        run_frame("idle_in_frame", 100, 1'b0, 8'hd5, 1'b1, 7'b0100100);
        run_block_error("bad_sync_header", 2'b11);
        run_block_error("data_between_frames", 2'b10);

        // with the receiver off a valid frame leaves no trace
        cfg_rx_enable = 1'b0;
        make_frame(96, 1'b0);
        beats = 0;
        pulses = 0;
        transmit(8'hd5, 1'b0);
        repeat (8) put_block(2'b01, idle_blk);
        errs = 0;
        assert (beats == 0 && pulses == 0) else begin
            $display("mismatch at %0t: rx_disabled gave %0d beats and %0d status pulses",
                     $time, beats, pulses);
            errs++;
        end
        report_test("rx_disabled", errs);
        cfg_rx_enable = 1'b1;

        assert (i_dut.i_assertions.fail_count == 0) else begin
            $display("bound assertions fired %0d times", i_dut.i_assertions.fail_count);
            failed_names.push_back("bound_assertions");
        end
        $display("%0d tests run, %0d failed", tests, failed_names.size());
        if (failed_names.size() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
logic/baser_rx_pkg.sv
logic/baser_block_if.sv
logic/baser_block_decoder.sv
logic/baser_crc_checker.sv
logic/baser_frame_fsm.sv
logic/baser_rx_top.sv
sim/baser_rx_assertions.sv
sim/baser_rx_tb.sv

// File: Bender.yml
package:
  name: baser_rx

sources:
  - include_dirs:
      - include
    files:
      - logic/baser_rx_pkg.sv
      - logic/baser_block_if.sv
      - logic/baser_block_decoder.sv
      - logic/baser_crc_checker.sv
      - logic/baser_frame_fsm.sv
      - logic/baser_rx_top.sv
      - target: simulation
        files:
          - sim/baser_rx_assertions.sv
          - sim/baser_rx_tb.sv
